// ==== Bender.yml ====
package:
  name: ma_stage

sources:
  - files:
      - verilog/ma_pkg.sv
      - verilog/exma_regs.sv
      - verilog/branch_unit.sv
      - verilog/load_decoder.sv
      - verilog/ma_lane.sv
      - verilog/tmr_voter.sv
      - verilog/ma_stage_top.sv
  - target: simulation
    files:
      - sim/tb_ma_stage.sv

// ==== ma_stage.f ====
verilog/ma_pkg.sv
verilog/exma_regs.sv
verilog/branch_unit.sv
verilog/load_decoder.sv
verilog/ma_lane.sv
verilog/tmr_voter.sv
verilog/ma_stage_top.sv
sim/tb_ma_stage.sv

// ==== sim/tb_ma_stage.sv ====
`timescale 1ns/10ps

module tb_ma_stage import ma_pkg::*; ();

    localparam word_t BOOT       = 32'h0000_1000;
    localparam int    MAX_CYCLES = 400;      // run takes about 70 cycles

    typedef struct packed {
        int       acc;                       // first cycle in MA
        int       due;                       // cycle the write-back shows up
        logic     lsu;
        logic     toc;
        word_t    toc_addr;
        logic     we;
        rf_addr_t rd;
        word_t    val;
        word_t    rst;                       // reset point after retirement
    } exp_t;

    logic s_clk_i, rst_i, valid_i, we_i, rvc_i, lsu_ready_i;
    unit_t    unit_i;
    funct_t   funct_i;
    rf_addr_t rd_i, mawb_rd_o;
    word_t    val_i, target_i, lsu_data_i, toc_addr_o, mawb_val_o, rst_point_o;
    logic     toc_o, flush_o, stall_o, mawb_we_o, vote_err_o;

    exp_t  exp_q [$];                        // model queue with the oldest first
    exp_t  head;
    word_t model_pc;                         // reset point as the model sees it
    word_t cur_rst;
    int    cyc;
    logic  chk_on, force_on, in_ma, exp_toc, exp_stall;
    funct_t ld_fn [5] = '{F_LB, F_LH, F_LW, F_LBU, F_LHU};

    ma_stage_top #(.BOOT_ADDR(BOOT)) uut (.*);

    initial begin
        s_clk_i = 1'b0;
        forever #10 s_clk_i = ~s_clk_i;     // 20 ns period
    end

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string what, input word_t got, input word_t want);
        abort_run($sformatf("Fail at %0d ns: %s is %h, expected %h",
                            $time, what, got, want));
    endtask

    // load model shifts the addressed part down to bit 0
    function automatic word_t ref_load(input word_t data, input funct_t fn,
                                       input logic [1:0] off);
        word_t b;
        word_t h;
        b = data >> (off * 8);
        h = data >> (off[1] * 16);           // halfword picked by address bit 1
        case (fn)
            F_LB:    return {{24{b[7]}}, b[7:0]};
            F_LBU:   return {24'd0, b[7:0]};
            F_LH:    return {{16{h[15]}}, h[15:0]};
            F_LHU:   return {16'd0, h[15:0]};
            default: return data;
        endcase
    endfunction

    task automatic idle();
        @(posedge s_clk_i);
        #2;
        valid_i = 1'b0;
    endtask

    // drive one instruction and queue what it should produce
    task automatic send(input unit_t unit, input funct_t fn, input rf_addr_t rd,
                        input logic we, input logic rvc, input word_t val,
                        input word_t target, input word_t data, input int hold);
        exp_t  e;
        word_t link;
        @(posedge s_clk_i);
        #2;
        valid_i  = 1'b1;
        unit_i   = unit;
        funct_i  = fn;
        rd_i     = rd;
        we_i     = we;
        rvc_i    = rvc;
        val_i    = val;
        target_i = target;
        if (unit == UNIT_LSU) lsu_data_i = data;
        link       = model_pc + (rvc ? 32'd2 : 32'd4);
        e.acc      = cyc + 1;
        e.due      = cyc + 2 + hold;         // every stalled cycle delays retirement
        e.lsu      = (unit == UNIT_LSU);
        e.toc      = (unit == UNIT_BRU) && (fn == F_JUMP || (fn == F_BRANCH && val[0]));
        e.toc_addr = target;
        e.we       = we;
        e.rd       = rd;
        e.val      = (unit == UNIT_LSU) ? ref_load(data, fn, val[1:0]) :
                     (unit == UNIT_BRU) ? link : val;
        model_pc   = e.toc ? target : link;
        e.rst      = model_pc;
        exp_q.push_back(e);
    endtask

    always @(posedge s_clk_i) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYCLES) begin
            abort_run($sformatf("timeout: run passed %0d cycles", MAX_CYCLES));
        end
    end

    // mid-cycle check of all outputs against the model
    always @(negedge s_clk_i) begin
        if (chk_on) begin
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                head = exp_q.pop_front();
                assert (mawb_we_o == head.we) else
                    value_error("mawb_we_o", mawb_we_o, head.we);
                if (head.we) begin
                    assert (mawb_rd_o == head.rd) else
                        value_error("mawb_rd_o", mawb_rd_o, head.rd);
                    assert (mawb_val_o == head.val) else
                        value_error("mawb_val_o", mawb_val_o, head.val);
                end
                cur_rst = head.rst;
            end else begin
                assert (!mawb_we_o) else value_error("mawb_we_o", mawb_we_o, 0);
            end
            assert (rst_point_o == cur_rst) else
                value_error("rst_point_o", rst_point_o, cur_rst);
            in_ma     = (exp_q.size() > 0) && (exp_q[0].acc <= cyc);
            head      = exp_q.size() > 0 ? exp_q[0] : '0;
            exp_toc   = in_ma && head.toc;
            exp_stall = in_ma && head.lsu && !lsu_ready_i;
            assert (toc_o == exp_toc) else value_error("toc_o", toc_o, exp_toc);
            assert (flush_o == exp_toc) else value_error("flush_o", flush_o, exp_toc);
            if (exp_toc) begin
                assert (toc_addr_o == head.toc_addr) else
                    value_error("toc_addr_o", toc_addr_o, head.toc_addr);
            end
            assert (stall_o == exp_stall) else value_error("stall_o", stall_o, exp_stall);
            assert (vote_err_o == force_on) else
                value_error("vote_err_o", vote_err_o, force_on);
        end
    end

    initial begin
        word_t fin;
        int    seed_val;
        seed_val    = $urandom(86637);
        rst_i       = 1'b1;
        valid_i     = 1'b0;
        we_i        = 1'b0;
        rvc_i       = 1'b0;
        lsu_ready_i = 1'b1;
        unit_i = UNIT_ALU;
        funct_i = '0;
        rd_i = '0;
        val_i = '0;
        target_i = '0;
        lsu_data_i = '0;
        cyc      = 0;
        chk_on   = 1'b0;
        force_on = 1'b0;
        model_pc = BOOT;
        cur_rst  = BOOT;
        repeat (2) @(posedge s_clk_i);
        #2;
        rst_i  = 1'b0;
        chk_on = 1'b1;                       // reset values checked from here on
        idle();
        send(UNIT_ALU, 3'd0, 5'd3, 1'b1, 1'b0, 32'h1234_5678, '0, '0, 0);
        send(UNIT_ALU, 3'd0, 5'd4, 1'b1, 1'b1, 32'hCAFE_0001, '0, '0, 0);  // compressed
        send(UNIT_ALU, 3'd0, 5'd5, 1'b0, 1'b0, 32'h0000_0042, '0, '0, 0);  // no write
        idle();
        send(UNIT_BRU, F_JUMP, 5'd1, 1'b1, 1'b0, '0, BOOT + 32'h100, '0, 0);
        send(UNIT_BRU, F_BRANCH, 5'd0, 1'b0, 1'b0, 32'd1, BOOT + 32'h40, '0, 0);  // taken
        send(UNIT_BRU, F_BRANCH, 5'd0, 1'b0, 1'b0, 32'd0, BOOT + 32'h80, '0, 0);  // not taken
        send(UNIT_BRU, F_JUMP, 5'd1, 1'b1, 1'b1, '0, BOOT + 32'h200, '0, 0);
        idle();
        foreach (ld_fn[i]) begin
            for (int off = 0; off < 4; off++) begin
                send(UNIT_LSU, ld_fn[i], rf_addr_t'($urandom_range(31, 1)), 1'b1, 1'b0,
                     {$urandom} & 32'hFFFF_FFFC | off, '0, $urandom, 0);
                idle();                      // keep lsu_data_i steady through MA
            end
        end
        fin = $urandom;
        send(UNIT_LSU, F_LH, 5'd9, 1'b1, 1'b0, 32'h0000_2002, '0, fin, 3);
        lsu_ready_i = 1'b0;                  // bus transfer extended for 3 cycles
        repeat (3) begin
            @(posedge s_clk_i);
            #2;
            valid_i    = 1'b1;               // offered while stalled and ignored
            val_i      = $urandom;
            lsu_data_i = $urandom;
        end
        send(UNIT_ALU, 3'd0, 5'd10, 1'b1, 1'b0, 32'h0BAD_F00D, '0, '0, 0);
        lsu_ready_i = 1'b1;
        lsu_data_i  = fin;                   // data present when the stall ends
        idle();
        idle();
        force uut.g_lane[1].u_lane.rst_point_o = 32'hDEAD_BEE0;
        force uut.g_lane[2].u_lane.wb_val = 32'hA5A5_5A5A;
        force_on = 1'b1;                     // one bad lane that the majority outvotes
        send(UNIT_ALU, 3'd0, 5'd11, 1'b1, 1'b0, 32'h7777_0000, '0, '0, 0);
        send(UNIT_ALU, 3'd0, 5'd12, 1'b1, 1'b1, 32'h0000_8888, '0, '0, 0);
        repeat (3) idle();
        release uut.g_lane[1].u_lane.rst_point_o;
        release uut.g_lane[2].u_lane.wb_val;
        force_on = 1'b0;
        while (exp_q.size() != 0) @(posedge s_clk_i);
        repeat (2) idle();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== verilog/branch_unit.sv ====
`timescale 1ns/10ps

module branch_unit import ma_pkg::*; (
    input  logic   active_i,   // valid BRU instruction in MA
    input  funct_t funct_i,    // F_BRANCH or F_JUMP
    input  logic   cond_i,     // branch comparison result from EX
    input  word_t  pc_i,       // address of the instruction (reset point)
    input  logic   rvc_i,      // compressed, 2-byte instruction
    output logic   taken_o,    // transfer of control
    output word_t  link_o      // return address, also the sequential next pc
);

    word_t incr;
    logic  is_jump;
    logic  is_branch;

    assign is_jump   = (funct_i == F_JUMP);
    assign is_branch = (funct_i == F_BRANCH);

    // every taken branch or jump redirects, no predictor here
    assign taken_o = active_i & (is_jump | (is_branch & cond_i));

    // 16-bit instructions step by 2
    assign incr = rvc_i ? word_t'(2) : word_t'(4);

    assign link_o = pc_i + incr;

endmodule

// ==== verilog/exma_regs.sv ====
`timescale 1ns/10ps

module exma_regs import ma_pkg::*; (
    input  logic     s_clk_i,                  // clock
    input  logic     rst_i,                    // sync reset, active high
    input  logic     hold_i,                   // keep current contents (stall)

    input  logic     valid_i,                  // instruction offered
    input  unit_t    unit_i,
    input  funct_t   funct_i,
    input  rf_addr_t rd_i,
    input  logic     we_i,                     // writes a register
    input  logic     rvc_i,                    // compressed instruction
    input  word_t    val_i,                    // EX result / load address / branch cond
    input  word_t    target_i,                 // branch target

    output logic     exma_valid_o  [NREP],
    output unit_t    exma_unit_o   [NREP],
    output funct_t   exma_funct_o  [NREP],
    output rf_addr_t exma_rd_o     [NREP],
    output logic     exma_we_o     [NREP],
    output logic     exma_rvc_o    [NREP],
    output word_t    exma_val_o    [NREP],
    output word_t    exma_target_o [NREP]
);

    // each copy is its own set of flops, a hit in one copy gets outvoted later
    for (genvar k = 0; k < NREP; k++) begin : g_copy
        always_ff @(posedge s_clk_i) begin
            if (rst_i) begin
                exma_valid_o[k]  <= 1'b0;
                exma_unit_o[k]   <= UNIT_ALU;
                exma_funct_o[k]  <= '0;
                exma_rd_o[k]     <= '0;
                exma_we_o[k]     <= 1'b0;
                exma_rvc_o[k]    <= 1'b0;
                exma_val_o[k]    <= '0;
                exma_target_o[k] <= '0;
            end else if (!hold_i) begin       // under stall valid_i is ignored
                exma_valid_o[k]  <= valid_i;
                exma_unit_o[k]   <= unit_i;
                exma_funct_o[k]  <= funct_i;
                exma_rd_o[k]     <= rd_i;
                exma_we_o[k]     <= we_i;
                exma_rvc_o[k]    <= rvc_i;
                exma_val_o[k]    <= val_i;
                exma_target_o[k] <= target_i;
            end
        end
    end

endmodule

// ==== verilog/load_decoder.sv ====
`timescale 1ns/10ps

module load_decoder import ma_pkg::*; (
    input  word_t    data_i,      // raw word from the data bus
    input  ld_info_t ld_info_i,   // {funct, addr[1:0]}
    output word_t    data_o       // aligned and extended value
);

    funct_t     funct;
    logic [1:0] offs;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    assign funct = ld_info_i[4:2];
    assign offs  = ld_info_i[1:0];

    // byte lane picked by both address bits
    always_comb begin
        case (offs)
            2'd0:    byte_sel = data_i[7:0];
            2'd1:    byte_sel = data_i[15:8];
            2'd2:    byte_sel = data_i[23:16];
            default: byte_sel = data_i[31:24];
        endcase
    end

    assign half_sel = offs[1] ? data_i[31:16] : data_i[15:0];  // halfword by bit 1

    always_comb begin
        case (funct)
            F_LB:    data_o = {{24{byte_sel[7]}}, byte_sel};
            F_LBU:   data_o = {24'd0, byte_sel};
            F_LH:    data_o = {{16{half_sel[15]}}, half_sel};
            F_LHU:   data_o = {16'd0, half_sel};
            default: data_o = data_i;                          // F_LW, whole word
        endcase
    end

endmodule

// ==== verilog/ma_lane.sv ====
`timescale 1ns/10ps

module ma_lane import ma_pkg::*; #(
    parameter word_t BOOT_ADDR = 32'h0000_0000     // reset point after reset
) (
    input  logic      s_clk_i,
    input  logic      rst_i,
    input  logic      lsu_ready_i,                  // low extends the bus transfer
    input  word_t     lsu_data_i,                   // loaded word

    input  logic      exma_valid_i,                 // this lane's copy of EX/MA
    input  unit_t     exma_unit_i,
    input  funct_t    exma_funct_i,
    input  rf_addr_t  exma_rd_i,
    input  logic      exma_we_i,
    input  logic      exma_rvc_i,
    input  word_t     exma_val_i,
    input  word_t     exma_target_i,

    output lane_out_t lane_o,                       // goes to the voter
    output word_t     rst_point_o                   // address of instruction in MA
);

    logic     is_lsu;
    logic     is_bru;
    logic     stall;
    logic     retire;
    logic     taken;
    word_t    link;
    word_t    toc_addr;
    word_t    write_val;
    word_t    rst_point_q;
    word_t    ld_data;
    word_t    wb_val;
    logic     mawb_we_q;
    logic     mawb_lsu_q;
    rf_addr_t mawb_rd_q;
    word_t    mawb_val_q;
    ld_info_t mawb_ldi_q;

    assign is_lsu = exma_valid_i & (exma_unit_i == UNIT_LSU);
    assign is_bru = exma_valid_i & (exma_unit_i == UNIT_BRU);

    assign stall  = is_lsu & ~lsu_ready_i;    // wait for the data bus
    assign retire = exma_valid_i & ~stall;

    branch_unit u_bru (
        .active_i (is_bru),
        .funct_i  (exma_funct_i),
        .cond_i   (exma_val_i[0]),            // comparison result rides in bit 0
        .pc_i     (rst_point_q),
        .rvc_i    (exma_rvc_i),
        .taken_o  (taken),
        .link_o   (link)
    );

    assign toc_addr = taken ? exma_target_i : link;

    // reset point follows retired instructions only
    always_ff @(posedge s_clk_i) begin
        if (rst_i) begin
            rst_point_q <= BOOT_ADDR;
        end else if (retire) begin
            rst_point_q <= toc_addr;
        end
    end

    // result select, loads keep the raw word until WB
    assign write_val = is_lsu ? lsu_data_i :
                       is_bru ? link : exma_val_i;

    // MA/WB register, bubble while stalled or slot empty
    always_ff @(posedge s_clk_i) begin
        if (rst_i) begin
            mawb_we_q  <= 1'b0;
            mawb_lsu_q <= 1'b0;
            mawb_rd_q  <= '0;
            mawb_val_q <= '0;
            mawb_ldi_q <= '0;
        end else begin
            mawb_we_q  <= retire & exma_we_i;
            mawb_lsu_q <= retire & is_lsu;
            mawb_rd_q  <= exma_rd_i;
            mawb_val_q <= write_val;
            mawb_ldi_q <= {exma_funct_i, exma_val_i[1:0]};  // funct + byte offset
        end
    end

    // write-back side, decode the loaded word
    load_decoder u_ld_dec (
        .data_i    (mawb_val_q),
        .ld_info_i (mawb_ldi_q),
        .data_o    (ld_data)
    );

    assign wb_val = mawb_lsu_q ? ld_data : mawb_val_q;

    assign lane_o      = {toc_addr, stall, taken, mawb_we_q, mawb_rd_q, wb_val};
    assign rst_point_o = rst_point_q;

endmodule

// ==== verilog/ma_pkg.sv ====
package ma_pkg;

    // three replicas, the majority vote is defined for exactly three
    localparam int NREP = 3;

    typedef logic [31:0] word_t;     // data / address word
    typedef logic [4:0]  rf_addr_t;  // register file address
    typedef logic [1:0]  unit_t;     // which unit executed the instruction
    typedef logic [2:0]  funct_t;    // function field
    typedef logic [4:0]  ld_info_t;  // {funct, addr[1:0]} kept for write-back decode

    // unit codes
    localparam unit_t UNIT_ALU = 2'd0;
    localparam unit_t UNIT_BRU = 2'd1;
    localparam unit_t UNIT_LSU = 2'd2;

    // branch unit functions
    localparam funct_t F_BRANCH = 3'b000;  // conditional, condition in val[0]
    localparam funct_t F_JUMP   = 3'b001;  // unconditional

    // load functions, RISC-V funct3
    localparam funct_t F_LB  = 3'b000;
    localparam funct_t F_LH  = 3'b001;
    localparam funct_t F_LW  = 3'b010;
    localparam funct_t F_LBU = 3'b100;
    localparam funct_t F_LHU = 3'b101;

    // per-lane outputs that go through the voter, packed msb first as
    // {toc_addr, stall, toc, mawb_we, mawb_rd, mawb_val}
    localparam int LANE_W = $bits(word_t) + 3 + $bits(rf_addr_t) + $bits(word_t);

    typedef logic [LANE_W-1:0] lane_out_t;

endpackage

// ==== verilog/ma_stage_top.sv ====
`timescale 1ns/10ps

module ma_stage_top import ma_pkg::*; #(
    parameter word_t BOOT_ADDR = 32'h0000_0000   // first reset point
) (
    input  logic     s_clk_i,
    input  logic     rst_i,

    input  logic     valid_i,        // accepted when stall_o is low
    input  unit_t    unit_i,
    input  funct_t   funct_i,
    input  rf_addr_t rd_i,
    input  logic     we_i,
    input  logic     rvc_i,
    input  word_t    val_i,
    input  word_t    target_i,
    input  word_t    lsu_data_i,
    input  logic     lsu_ready_i,

    output logic     toc_o,
    output logic     flush_o,
    output word_t    toc_addr_o,
    output logic     stall_o,
    output logic     mawb_we_o,
    output rf_addr_t mawb_rd_o,
    output word_t    mawb_val_o,
    output word_t    rst_point_o,
    output logic     vote_err_o
);

    logic      exma_valid  [NREP];
    unit_t     exma_unit   [NREP];
    funct_t    exma_funct  [NREP];
    rf_addr_t  exma_rd     [NREP];
    logic      exma_we     [NREP];
    logic      exma_rvc    [NREP];
    word_t     exma_val    [NREP];
    word_t     exma_target [NREP];
    lane_out_t lane        [NREP];
    word_t     rst_point   [NREP];

    exma_regs u_exma (
        .s_clk_i, .rst_i,
        .hold_i        (stall_o),        // voted stall freezes EX/MA
        .valid_i, .unit_i, .funct_i, .rd_i, .we_i, .rvc_i, .val_i, .target_i,
        .exma_valid_o  (exma_valid),
        .exma_unit_o   (exma_unit),
        .exma_funct_o  (exma_funct),
        .exma_rd_o     (exma_rd),
        .exma_we_o     (exma_we),
        .exma_rvc_o    (exma_rvc),
        .exma_val_o    (exma_val),
        .exma_target_o (exma_target)
    );

    for (genvar k = 0; k < NREP; k++) begin : g_lane
        ma_lane #(.BOOT_ADDR(BOOT_ADDR)) u_lane (
            .s_clk_i, .rst_i, .lsu_ready_i, .lsu_data_i,
            .exma_valid_i  (exma_valid[k]),
            .exma_unit_i   (exma_unit[k]),
            .exma_funct_i  (exma_funct[k]),
            .exma_rd_i     (exma_rd[k]),
            .exma_we_i     (exma_we[k]),
            .exma_rvc_i    (exma_rvc[k]),
            .exma_val_i    (exma_val[k]),
            .exma_target_i (exma_target[k]),
            .lane_o        (lane[k]),
            .rst_point_o   (rst_point[k])
        );
    end

    tmr_voter u_voter (
        .lane_i      (lane),
        .rst_point_i (rst_point),
        .toc_o, .flush_o, .toc_addr_o, .stall_o,
        .mawb_we_o, .mawb_rd_o, .mawb_val_o, .rst_point_o, .vote_err_o
    );

endmodule

// ==== verilog/tmr_voter.sv ====
`timescale 1ns/10ps

module tmr_voter import ma_pkg::*; (
    input  lane_out_t lane_i      [NREP],   // one packed output set per lane
    input  word_t     rst_point_i [NREP],

    output logic      toc_o,
    output logic      flush_o,
    output word_t     toc_addr_o,
    output logic      stall_o,
    output logic      mawb_we_o,
    output rf_addr_t  mawb_rd_o,
    output word_t     mawb_val_o,
    output word_t     rst_point_o,
    output logic      vote_err_o            // lanes disagree this cycle
);

    localparam int VW = LANE_W + $bits(word_t);

    logic [VW-1:0] rep [NREP];
    logic [VW-1:0] voted;
    lane_out_t     lane_v;

    // everything voted as one wide vector
    for (genvar k = 0; k < NREP; k++) begin : g_rep
        assign rep[k] = {lane_i[k], rst_point_i[k]};
    end

    // bitwise 2-of-3
    assign voted = (rep[0] & rep[1]) | (rep[0] & rep[2]) | (rep[1] & rep[2]);

    assign {lane_v, rst_point_o} = voted;

    assign {toc_addr_o, stall_o, toc_o, mawb_we_o, mawb_rd_o, mawb_val_o} = lane_v;

    assign flush_o = toc_o;   // upstream flushes on every toc

    assign vote_err_o = (rep[0] != rep[1]) | (rep[1] != rep[2]);

endmodule
